// ==== filelist.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/coreCommandIf.sv
rtl/aluUnit.sv
rtl/instrSequencer.sv
rtl/dataPath.sv
rtl/core6502Lite.sv
tests/core6502Lite_tb.sv

// ==== Bender.yml ====
package:
  name: core6502_lite

export_include_dirs:
  - rtl

sources:
  - rtl/core_pkg.sv
  - rtl/coreCommandIf.sv
  - rtl/aluUnit.sv
  - rtl/instrSequencer.sv
  - rtl/dataPath.sv
  - rtl/core6502Lite.sv
  - target: test
    files:
      - tests/core6502Lite_tb.sv

// ==== tests/core6502Lite_tb.sv ====
`include "core_config.svh"

module core6502Lite_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [7:0] opLdx = 8'hA2;
	localparam logic [7:0] opLdy = 8'hA0;
	localparam logic [7:0] opTax = 8'hAA;
	localparam logic [7:0] opTxa = 8'h8A;
	localparam logic [7:0] opInx = 8'hE8;
	localparam logic [7:0] opClc = 8'h18;
	localparam logic [7:0] opSec = 8'h38;
	localparam logic [7:0] opNop = 8'hEA;
	localparam logic [7:0] opJmp = 8'h4C;
	localparam logic [7:0] opBeq = 8'hF0;
	localparam logic [7:0] opBne = 8'hD0;

	logic phi0;
	logic reset;
	logic [7:0] dataIn;
	logic [7:0] dataOut;
	logic [15:0] addr;
	logic rnW;
	logic sync;

	logic [7:0] mem [0:65535];	// Whole 6502 address space
	logic [15:0] expAddr [0:31];	// Expected write list
	logic [7:0] expData [0:31];
	int expCount;
	int writeCount;
	int cycleCount;
	logic [15:0] progPc;
	logic [15:0] loopAddr;
	logic loopSeen;		// Set once the JMP has been fetched the first time
	logic programReady;
	integer seed;

	core6502Lite i_dut (
		.phi0(phi0),
		.reset(reset),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.addr(addr),
		.rnW(rnW),
		.sync(sync)
	);

	always #10 phi0 = ~phi0;

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	function automatic logic [7:0] randomByte();
		integer r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// Group one opcode built from its fields
	function automatic logic [7:0] groupOneOpcode(input logic [2:0] aaa, input logic [2:0] bbb);
		core_pkg::opcodeWord op;
		op.fields.aaa = aaa;
		op.fields.bbb = bbb;
		op.fields.cc = 2'b01;
		return op.raw;
	endfunction

	task automatic putByte(input logic [7:0] b);
		mem[progPc] = b;
		progPc = progPc + 1'b1;
	endtask

	task automatic putTwoByte(input logic [7:0] op, input logic [7:0] operand);
		putByte(op);
		putByte(operand);
		cycleCount += 2;	// Immediate and branch forms
	endtask

	task automatic putImplied(input logic [7:0] op);
		putByte(op);
		cycleCount += 2;
	endtask

	task automatic putStore(input logic [15:0] a, input logic [7:0] value, input bit expectIt);
		putByte(groupOneOpcode(3'b100, 3'b011));	// STA abs
		putByte(a[7:0]);
		putByte(a[15:8]);
		cycleCount += 4;
		if (expectIt) begin
			expAddr[expCount] = a;
			expData[expCount] = value;
			expCount++;
		end
	endtask

	// Memory answers 1 ns after the edge, writes land on the edge
	always @(posedge phi0) begin
		#1;
		dataIn = mem[addr];
	end

	always @(posedge phi0) begin
		if (!reset && !rnW) begin
			mem[addr] <= dataOut;
			writeCount <= writeCount + 1;
		end
	end

	assert property (@(posedge phi0) $fell(reset) |-> sync && rnW && addr == `CORE_RESET_PC)
		else failRun($sformatf("[ERROR] %0t ns: first cycle after reset has sync %b rnW %b addr %h",
			$time, $sampled(sync), $sampled(rnW), $sampled(addr)));

	assert property (@(posedge phi0) disable iff (reset) !(!rnW && sync))
		else failRun($sformatf("[ERROR] %0t ns: memory write during opcode fetch", $time));

	assert property (@(posedge phi0) disable iff (reset)
		!rnW |-> (writeCount < expCount && addr == expAddr[writeCount] &&
		dataOut == expData[writeCount]))
		else failRun($sformatf("[ERROR] %0t ns: write %0d went to %h with data %h",
			$time, $sampled(writeCount), $sampled(addr), $sampled(dataOut)));

	initial begin
		logic [7:0] v;
		logic [7:0] w;
		logic [8:0] sum;
		logic [15:0] st;
		phi0 = 1'b0;
		reset = 1'b1;
		dataIn = '0;
		seed = 32'he1c1b255;
		progPc = `CORE_RESET_PC;
		cycleCount = 2;		// Reset cycles
		expCount = 0;
		writeCount = 0;
		loopSeen = 1'b0;
		programReady = 1'b0;
		st = 16'h0300;
		for (int k = 0; k < 3; k++) begin	// ORA, AND, EOR
			v = randomByte();
			w = randomByte();
			putTwoByte(groupOneOpcode(3'b101, 3'b010), v);
			putTwoByte(groupOneOpcode(k[2:0], 3'b010), w);
			putStore(st, (k == 0) ? (v | w) : (k == 1) ? (v & w) : (v ^ w), 1'b1);
			st++;
		end
		for (int c = 0; c < 2; c++) begin	// ADC from clear then set carry
			v = randomByte();
			w = randomByte();
			v[7] = (c == 0);	// First round carries out, second one does not
			w[7] = (c == 0);
			putImplied((c == 0) ? opClc : opSec);
			putTwoByte(groupOneOpcode(3'b101, 3'b010), v);
			putTwoByte(groupOneOpcode(3'b011, 3'b010), w);
			sum = {1'b0, v} + {1'b0, w} + 9'(c);
			putStore(st, sum[7:0], 1'b1);
			st++;
			w = randomByte();
			putTwoByte(groupOneOpcode(3'b011, 3'b010), w);
			sum = {1'b0, sum[7:0]} + {1'b0, w} + {8'd0, sum[8]};	// Carry out of the first sum
			putStore(st, sum[7:0], 1'b1);
			st++;
		end
		v = randomByte();
		putTwoByte(opLdx, v);
		putImplied(opInx);
		putImplied(opTxa);
		putStore(st, v + 8'd1, 1'b1);
		st++;
		putTwoByte(opLdy, randomByte());
		putImplied(opTax);
		putTwoByte(groupOneOpcode(3'b101, 3'b010), 8'h00);	// Z set
		putTwoByte(opBeq, 8'd5);
		putTwoByte(groupOneOpcode(3'b101, 3'b010), 8'hA5);	// Skipped marker store
		putStore(16'h03F0, 8'hA5, 1'b0);
		putTwoByte(opBne, 8'd5);		// Falls through
		putTwoByte(groupOneOpcode(3'b101, 3'b010), 8'h3C);
		putStore(st, 8'h3C, 1'b1);
		putImplied(opNop);
		loopAddr = progPc;
		putByte(opJmp);
		putByte(loopAddr[7:0]);
		putByte(loopAddr[15:8]);
		cycleCount += 4;	// JMP plus the fetch that closes the loop
		programReady = 1'b1;
		repeat (2) @(posedge phi0);
		#1;
		reset = 1'b0;
	end

	// Final JMP loop reached, and taken once back onto itself
	always @(negedge phi0) begin
		if (!reset && sync && addr == loopAddr) begin
			if (!loopSeen) begin
				loopSeen = 1'b1;
			end else if (writeCount == expCount) begin
				$display("All tests passed");
				$finish;
			end else begin
				failRun($sformatf("[ERROR] %0t ns: final loop reached after %0d of %0d writes",
					$time, writeCount, expCount));
			end
		end
	end

	initial begin
		wait (programReady);
		#((cycleCount + 50) * 20);
		failRun("Timeout: the program never reached its final JMP loop");
	end

endmodule

// ==== rtl/core6502Lite.sv ====
`include "core_config.svh"

module core6502Lite (
	input logic phi0,
	input logic reset,
	input logic [`CORE_DATA_WIDTH-1:0] dataIn,
	output logic [`CORE_DATA_WIDTH-1:0] dataOut,
	output logic [`CORE_ADDR_WIDTH-1:0] addr,
	output logic rnW,
	output logic sync
);

	coreCommandIf cmd ();	// Control to datapath commands

	instrSequencer i_seq (
		.phi0(phi0),
		.reset(reset),
		.dataIn(dataIn),
		.cmd(cmd.control),
		.sync(sync)
	);

	dataPath i_dp (
		.phi0(phi0),
		.reset(reset),
		.dataIn(dataIn),
		.cmd(cmd.datapath),
		.addr(addr),
		.dataOut(dataOut)
	);

	assign rnW = ~cmd.writeMem;		// Read unless storing

endmodule

// ==== rtl/dataPath.sv ====
`include "core_config.svh"

module dataPath (
	input logic phi0,
	input logic reset,
	input logic [`CORE_DATA_WIDTH-1:0] dataIn,
	coreCommandIf.datapath cmd,
	output logic [`CORE_ADDR_WIDTH-1:0] addr,
	output logic [`CORE_DATA_WIDTH-1:0] dataOut
);

	logic [`CORE_DATA_WIDTH-1:0] regA;
	logic [`CORE_DATA_WIDTH-1:0] regX;
	logic [`CORE_DATA_WIDTH-1:0] regY;
	logic [`CORE_DATA_WIDTH-1:0] adl;
	logic [`CORE_DATA_WIDTH-1:0] adh;
	logic [`CORE_ADDR_WIDTH-1:0] pc;
	logic [`CORE_ADDR_WIDTH-1:0] pcNext;
	logic [`CORE_ADDR_WIDTH-1:0] branchOffset;
	logic [`CORE_DATA_WIDTH-1:0] aluA;
	logic [`CORE_DATA_WIDTH-1:0] aluB;
	logic [`CORE_DATA_WIDTH-1:0] aluResult;
	logic aluCarry;
	logic aluZero;

	assign aluA = cmd.useX ? regX : regA;

	// The bus byte is an operand only when the PC steps over it
	assign aluB = cmd.pcInc ? dataIn : '0;

	aluUnit i_alu (
		.sel(cmd.aluSel),
		.opA(aluA),
		.opB(aluB),
		.carryIn(cmd.carryFlag),
		.result(aluResult),
		.carryOut(aluCarry),
		.zero(aluZero)
	);

	assign pcNext = pc + 1'b1;
	assign branchOffset = {{(`CORE_ADDR_WIDTH-`CORE_DATA_WIDTH){dataIn[`CORE_DATA_WIDTH-1]}},
		dataIn};

	always_ff @(posedge phi0) begin
		if (reset) begin
			pc <= `CORE_RESET_PC;
			cmd.zeroFlag <= 1'b0;
			cmd.carryFlag <= 1'b0;
		end else begin
			if (cmd.pcJump) begin
				pc <= {dataIn, adl};			// High byte straight off the bus
			end else if (cmd.pcBranch) begin
				pc <= pcNext + branchOffset;	// Relative to the next opcode
			end else if (cmd.pcInc) begin
				pc <= pcNext;
			end
			if (cmd.updateNz) begin
				cmd.zeroFlag <= aluZero;
			end
			if (cmd.setC) begin
				cmd.carryFlag <= 1'b1;
			end else if (cmd.clrC) begin
				cmd.carryFlag <= 1'b0;
			end else if (cmd.updateC) begin
				cmd.carryFlag <= aluCarry;
			end
		end
	end

	always_ff @(posedge phi0) begin
		if (cmd.loadA) regA <= aluResult;
		if (cmd.loadX) regX <= aluResult;
		if (cmd.loadY) regY <= aluResult;
		if (cmd.latchAdl) adl <= dataIn;
		if (cmd.latchAdh) adh <= dataIn;
	end

	assign addr = (cmd.addrSel == core_pkg::addrOperand) ? {adh, adl} : pc;
	assign dataOut = regA;		// Only STA writes

	assert property (@(posedge phi0) disable iff (reset) !(cmd.pcJump && cmd.pcBranch))
		else $error("jump and branch requested together");

endmodule

// ==== rtl/instrSequencer.sv ====
`include "core_config.svh"

module instrSequencer (
	input logic phi0,
	input logic reset,
	input logic [`CORE_DATA_WIDTH-1:0] dataIn,
	coreCommandIf.control cmd,
	output logic sync
);

	localparam logic [7:0] opLdx = 8'hA2;
	localparam logic [7:0] opLdy = 8'hA0;
	localparam logic [7:0] opTax = 8'hAA;
	localparam logic [7:0] opTxa = 8'h8A;
	localparam logic [7:0] opInx = 8'hE8;
	localparam logic [7:0] opClc = 8'h18;
	localparam logic [7:0] opSec = 8'h38;
	localparam logic [7:0] opNop = 8'hEA;
	localparam logic [7:0] opJmp = 8'h4C;
	localparam logic [7:0] opBeq = 8'hF0;
	localparam logic [7:0] opBne = 8'hD0;

	core_pkg::opcodeWord opcode;
	core_pkg::timingState state;
	core_pkg::timingState stateNext;
	core_pkg::aluOp groupOneOp;
	logic groupOneImm;
	logic isStaAbs;
	logic branchTaken;

	always_ff @(posedge phi0) begin
		if (reset) begin
			state <= core_pkg::tFetch;
		end else begin
			state <= stateNext;
		end
	end

	always_ff @(posedge phi0) begin
		if (state == core_pkg::tFetch) begin
			opcode.raw <= dataIn;	// Instruction register
		end
	end

	// Group one immediate forms, operation taken from aaa
	always_comb begin
		groupOneImm = (opcode.fields.cc == 2'b01) && (opcode.fields.bbb == 3'b010);
		groupOneOp = core_pkg::aluPassB;
		case (opcode.fields.aaa)
			3'b000: groupOneOp = core_pkg::aluOr;
			3'b001: groupOneOp = core_pkg::aluAnd;
			3'b010: groupOneOp = core_pkg::aluEor;
			3'b011: groupOneOp = core_pkg::aluAdc;
			3'b101: groupOneOp = core_pkg::aluPassB;	// LDA
			default: groupOneImm = 1'b0;				// No CMP or SBC here
		endcase
	end

	assign isStaAbs = (opcode.fields.cc == 2'b01) && (opcode.fields.bbb == 3'b011) &&
		(opcode.fields.aaa == 3'b100);

	// Bit 5 picks BEQ over BNE
	assign branchTaken = (cmd.zeroFlag == opcode.raw[5]);

	always_comb begin
		cmd.aluSel = core_pkg::aluPassB;
		cmd.useX = 1'b0;
		cmd.loadA = 1'b0;
		cmd.loadX = 1'b0;
		cmd.loadY = 1'b0;
		cmd.updateNz = 1'b0;
		cmd.updateC = 1'b0;
		cmd.setC = 1'b0;
		cmd.clrC = 1'b0;
		cmd.pcInc = 1'b0;
		cmd.pcJump = 1'b0;
		cmd.pcBranch = 1'b0;
		cmd.latchAdl = 1'b0;
		cmd.latchAdh = 1'b0;
		cmd.addrSel = core_pkg::addrPc;
		cmd.writeMem = 1'b0;
		sync = 1'b0;
		stateNext = core_pkg::tFetch;
		case (state)
			core_pkg::tFetch: begin
				sync = 1'b1;
				cmd.pcInc = 1'b1;
				stateNext = core_pkg::tOne;
			end
			core_pkg::tOne: begin
				if (groupOneImm) begin
					cmd.aluSel = groupOneOp;
					cmd.loadA = 1'b1;
					cmd.updateNz = 1'b1;
					cmd.updateC = (groupOneOp == core_pkg::aluAdc);
					cmd.pcInc = 1'b1;
				end else if (isStaAbs) begin
					cmd.latchAdl = 1'b1;
					cmd.pcInc = 1'b1;
					stateNext = core_pkg::tTwo;
				end else begin
					case (opcode.raw)
						opLdx: begin
							cmd.loadX = 1'b1;
							cmd.updateNz = 1'b1;
							cmd.pcInc = 1'b1;
						end
						opLdy: begin
							cmd.loadY = 1'b1;
							cmd.updateNz = 1'b1;
							cmd.pcInc = 1'b1;
						end
						opTax: begin
							cmd.aluSel = core_pkg::aluOr;	// A or zero
							cmd.loadX = 1'b1;
							cmd.updateNz = 1'b1;
						end
						opTxa: begin
							cmd.aluSel = core_pkg::aluOr;
							cmd.useX = 1'b1;
							cmd.loadA = 1'b1;
							cmd.updateNz = 1'b1;
						end
						opInx: begin
							cmd.aluSel = core_pkg::aluInc;
							cmd.useX = 1'b1;
							cmd.loadX = 1'b1;
							cmd.updateNz = 1'b1;
						end
						opClc: cmd.clrC = 1'b1;
						opSec: cmd.setC = 1'b1;
						opBeq, opBne: begin
							cmd.pcInc = 1'b1;				// Step over the offset
							cmd.pcBranch = branchTaken;
						end
						opJmp: begin
							cmd.latchAdl = 1'b1;
							cmd.pcInc = 1'b1;
							stateNext = core_pkg::tTwo;
						end
						opNop: cmd.pcJump = 1'b0;			// Idle cycle
						default: cmd.pcJump = 1'b0;		// Unknown opcodes behave like NOP
					endcase
				end
			end
			core_pkg::tTwo: begin
				if (isStaAbs) begin
					cmd.latchAdh = 1'b1;
					cmd.pcInc = 1'b1;
					stateNext = core_pkg::tThree;
				end else begin
					cmd.pcJump = 1'b1;		// JMP high byte on the bus
				end
			end
			default: begin
				cmd.addrSel = core_pkg::addrOperand;	// STA write cycle
				cmd.writeMem = 1'b1;
			end
		endcase
	end

	assert property (@(posedge phi0) disable iff (reset) !(cmd.writeMem && sync))
		else $error("memory write during opcode fetch");

	assert property (@(posedge phi0) disable iff (reset)
		$onehot0({cmd.loadA, cmd.loadX, cmd.loadY}))
		else $error("more than one register load in a cycle");

endmodule

// ==== rtl/aluUnit.sv ====
`include "core_config.svh"

module aluUnit (
	input core_pkg::aluOp sel,
	input logic [`CORE_DATA_WIDTH-1:0] opA,
	input logic [`CORE_DATA_WIDTH-1:0] opB,
	input logic carryIn,
	output logic [`CORE_DATA_WIDTH-1:0] result,
	output logic carryOut,
	output logic zero
);

	logic [`CORE_DATA_WIDTH:0] sum;	// One extra bit for carry out

	assign sum = {1'b0, opA} + {1'b0, opB} + {{`CORE_DATA_WIDTH{1'b0}}, carryIn};

	always_comb begin
		carryOut = 1'b0;
		case (sel)
			core_pkg::aluOr: begin
				result = opA | opB;
			end
			core_pkg::aluAnd: begin
				result = opA & opB;
			end
			core_pkg::aluEor: begin
				result = opA ^ opB;
			end
			core_pkg::aluAdc: begin
				result = sum[`CORE_DATA_WIDTH-1:0];
				carryOut = sum[`CORE_DATA_WIDTH];
			end
			core_pkg::aluInc: begin
				result = opA + 1'b1;		// Wraps with no carry
			end
			default: begin
				result = opB;				// Immediate loads
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== rtl/coreCommandIf.sv ====
interface coreCommandIf;

	core_pkg::aluOp aluSel;
	logic useX;				// X instead of A as first ALU operand
	logic loadA;
	logic loadX;
	logic loadY;
	logic updateNz;
	logic updateC;
	logic setC;
	logic clrC;
	logic pcInc;
	logic pcJump;
	logic pcBranch;
	logic latchAdl;
	logic latchAdh;
	core_pkg::addrSource addrSel;
	logic writeMem;
	logic zeroFlag;			// Flag register contents
	logic carryFlag;

	modport control (
		output aluSel, useX, loadA, loadX, loadY, updateNz, updateC, setC, clrC,
		output pcInc, pcJump, pcBranch, latchAdl, latchAdh, addrSel, writeMem,
		input zeroFlag, carryFlag
	);

	modport datapath (
		input aluSel, useX, loadA, loadX, loadY, updateNz, updateC, setC, clrC,
		input pcInc, pcJump, pcBranch, latchAdl, latchAdh, addrSel, writeMem,
		output zeroFlag, carryFlag
	);

endinterface

// ==== rtl/core_pkg.sv ====
package core_pkg;

	// Classic 6502 opcode split used by the group-one ALU instructions
	typedef struct packed {
		logic [2:0] aaa;	// Operation
		logic [2:0] bbb;	// Addressing mode
		logic [1:0] cc;		// Instruction group
	} opcodeFields;

	typedef union packed {
		logic [7:0] raw;		// Whole opcode byte
		opcodeFields fields;	// Same byte seen as aaa/bbb/cc
	} opcodeWord;

	typedef enum logic [2:0] {
		aluPassB,	// Second operand straight through
		aluOr,
		aluAnd,
		aluEor,
		aluAdc,		// Sum with carry in
		aluInc		// First operand plus one
	} aluOp;

	typedef enum logic {
		addrPc,			// Program counter on the address bus
		addrOperand		// ADH:ADL on the address bus
	} addrSource;

	typedef enum logic [1:0] {
		tFetch,		// Opcode fetch cycle
		tOne,
		tTwo,
		tThree
	} timingState;

endpackage

// ==== rtl/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Program counter value loaded while reset is held
`define CORE_RESET_PC 16'h0200

// Data path and data bus width
`define CORE_DATA_WIDTH 8

// Address bus width
`define CORE_ADDR_WIDTH 16

`endif
